// File: build.f
+incdir+include
src/cache_pkg.sv
src/cache_fill_fsm.sv
src/tag_array.sv
src/data_array.sv
src/main_memory.sv
src/cache_ctrl.sv
src/cache_top.sv
tests/cache_tb.sv

// File: include/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ***************************************************************************
// address and data widths
// ***************************************************************************
`define CACHE_ADDR_W          16 // byte address width of the processor
`define CACHE_WORD_W          16 // one data word is two bytes

// ***************************************************************************
// cache geometry
// ***************************************************************************
`define CACHE_INDEX_W         6  // 64 sets in the direct-mapped cache
`define CACHE_OFFSET_W        4  // 16 bytes per block, offset steps by 2
`define CACHE_TAG_W           6  // whatever is left above index and offset
`define CACHE_WORDS_PER_BLOCK 8  // eight words are fetched on every miss

// main memory model
`define MEM_LATENCY           4     // cycles from a read strobe to its data-valid pulse
`define MEM_WORDS             32768 // the full 16-bit byte space counted in words

`endif

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cache_tb \
	-Mdir obj_dir -o cache_sim > build.log 2>&1 \
	&& ./obj_dir/cache_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not run to the end"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
	input  cache_pkg::cpu_req_t   cpu_req,
	input  cache_pkg::tag_entry_t entry,         // tag array line of the addressed set
	input  logic                  fsm_busy,      // a fill is in progress
	input  logic                  mem_read,      // read strobe from the fill FSM
	input  cache_pkg::addr_t      mem_read_addr,
	output logic                  hit,
	output logic                  stall,
	output logic                  miss_detected,
	output logic                  store_wr,      // write hit updates the data array too
	output cache_pkg::mem_req_t   mem_req
);

import cache_pkg::*;

tag_t cpu_tag;
logic tag_match; // the set holds the block of the requested address
logic access;    // the processor is reading or writing in this cycle
logic mem_wr;

// ***************************************************************************
// tag compare
// ***************************************************************************
assign cpu_tag   = cpu_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
assign tag_match = entry.valid && (entry.tag == cpu_tag);
assign access    = cpu_req.rd || cpu_req.wr;

assign hit = access && tag_match; // stays low through a fill until the tag is written

// only a read starts a fill since stores do not allocate
assign miss_detected = cpu_req.rd && !tag_match && !fsm_busy;

// the held read waits through the fill and the tag write cycle
assign stall = miss_detected || fsm_busy;

// ***************************************************************************
// write-through path
// ***************************************************************************
// a write never stalls while the FSM is idle, so it goes out right away
assign mem_wr   = cpu_req.wr && !fsm_busy;
assign store_wr = mem_wr && tag_match; // keep the cached copy in step with memory

// reads only while busy and writes only while idle, so the fields can share one request
always_comb begin
	mem_req.rd    = mem_read;
	mem_req.wr    = mem_wr;
	mem_req.addr  = mem_read ? mem_read_addr : cpu_req.addr;
	mem_req.wdata = cpu_req.wdata;
end

// stall can only come from a processor access, since the request is held during a fill
always_comb begin
	if (stall)
		a_stall_needs_access: assert (access)
			else $error("stall raised without a processor access");
end

endmodule

// File: src/cache_fill_fsm.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_fill_fsm (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                miss_detected,    // a read missed while the FSM was idle
	input  cache_pkg::addr_t    miss_addr,        // address of the read that missed
	input  cache_pkg::mem_rsp_t mem_rsp,          // data coming back from memory
	output logic                fsm_busy,         // high from the first read to the tag write
	output logic                mem_read,         // one strobe per word of the block
	output cache_pkg::addr_t    mem_read_addr,
	output logic                write_data_array, // returning word goes into the data array
	output cache_pkg::offset_t  fill_offset,      // byte offset of that word in the block
	output cache_pkg::word_t    fill_data,
	output logic                write_tag_array,  // block complete so the tag can be set valid
	output cache_pkg::addr_t    base_addr
);

import cache_pkg::*;

fill_state_t state_q, state_d;
addr_t       base_q;       // block aligned address of the miss
offset_t     rd_off_q;     // offset of the next read strobe
offset_t     wr_off_q;     // offset of the next word to arrive
logic        reads_done_q; // all eight reads have been strobed

// one extra bit catches the carry when the offset wraps past the last word
logic [`CACHE_OFFSET_W:0] rd_sum;
logic [`CACHE_OFFSET_W:0] wr_sum;

assign rd_sum = {1'b0, rd_off_q} + 2; // words are two bytes apart
assign wr_sum = {1'b0, wr_off_q} + 2;

// ***************************************************************************
// state register and next state
// ***************************************************************************
always_comb begin
	state_d = state_q;
	case (state_q)
		FILL_IDLE: if (miss_detected) state_d = FILL_BUSY;
		FILL_BUSY: if (write_data_array && wr_sum[`CACHE_OFFSET_W]) state_d = FILL_DONE; // eighth word
		FILL_DONE: state_d = FILL_IDLE; // the tag is written in this cycle
		default:   state_d = FILL_IDLE;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state_q      <= FILL_IDLE;
		rd_off_q     <= '0;
		wr_off_q     <= '0;
		reads_done_q <= 1'b0;
	end else begin
		state_q <= state_d;
		if (state_q == FILL_IDLE && miss_detected) begin
			rd_off_q     <= '0; // a new block always starts at its first word
			wr_off_q     <= '0;
			reads_done_q <= 1'b0;
		end
		if (mem_read) begin
			rd_off_q <= rd_sum[`CACHE_OFFSET_W-1:0];
			if (rd_sum[`CACHE_OFFSET_W])
				reads_done_q <= 1'b1; // stop strobing once the counter wraps
		end
		if (write_data_array)
			wr_off_q <= wr_sum[`CACHE_OFFSET_W-1:0]; // wraps back to 0 after the last word
	end
end

// block base of the read that missed, held for the whole fill
always_ff @(posedge clk) begin
	if (state_q == FILL_IDLE && miss_detected)
		base_q <= {miss_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
end

// ***************************************************************************
// outputs
// ***************************************************************************
assign fsm_busy         = (state_q != FILL_IDLE);
assign mem_read         = (state_q == FILL_BUSY) && !reads_done_q;
assign mem_read_addr    = base_q + addr_t'(rd_off_q);
assign write_data_array = (state_q == FILL_BUSY) && mem_rsp.valid;
assign fill_offset      = wr_off_q;
assign fill_data        = mem_rsp.data;
assign write_tag_array  = (state_q == FILL_DONE);
assign base_addr        = base_q;

// memory only answers reads that this FSM issued during a fill
a_no_rsp_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
	mem_rsp.valid |-> state_q != FILL_IDLE);

// every strobe has gone out before the eighth word arrives, so none leaks into the tag write
a_reads_before_last_word: assert property (@(posedge clk) disable iff (!arst_n)
	(write_data_array && wr_sum[`CACHE_OFFSET_W]) |-> reads_done_q);

endmodule

// File: src/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

// plain vectors for the widths that carry a meaning
typedef logic [`CACHE_ADDR_W-1:0]   addr_t;   // byte address
typedef logic [`CACHE_WORD_W-1:0]   word_t;   // data word
typedef logic [`CACHE_TAG_W-1:0]    tag_t;    // upper address bits kept in the tag array
typedef logic [`CACHE_INDEX_W-1:0]  index_t;  // selects one of the sets
typedef logic [`CACHE_OFFSET_W-1:0] offset_t; // byte offset inside a block

// one line of the tag array
typedef struct packed {
	logic valid; // the set holds a complete block
	tag_t tag;
} tag_entry_t;

// the processor keeps this request stable while stall is high
typedef struct packed {
	logic  rd;
	logic  wr;
	addr_t addr;
	word_t wdata;
} cpu_req_t;

// reads come from the fill FSM and writes from the write-through path
typedef struct packed {
	logic  rd;
	logic  wr;
	addr_t addr;
	word_t wdata;
} mem_req_t;

typedef struct packed {
	logic  valid; // pulses once per read strobe, in order
	word_t data;
} mem_rsp_t;

typedef enum logic [1:0] {FILL_IDLE, FILL_BUSY, FILL_DONE} fill_state_t;

endpackage

// File: src/cache_top.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_top (
	input  logic                clk,
	input  logic                arst_n,
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::word_t    rdata,  // valid in the cycle the access completes
	output logic                stall,  // the processor holds its request while this is high
	output logic                hit
);

import cache_pkg::*;

tag_entry_t entry;
logic       fsm_busy;
logic       miss_detected;
logic       mem_read;
addr_t      mem_read_addr;
addr_t      base_addr;
logic       write_data_array;
logic       write_tag_array;
offset_t    fill_offset;
word_t      fill_data;
logic       store_wr;
mem_req_t   mem_req;
mem_rsp_t   mem_rsp;
index_t     cpu_index;
index_t     fill_index;
index_t     tag_index;

// ***************************************************************************
// address fields
// ***************************************************************************
assign cpu_index  = cpu_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
assign fill_index = base_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
assign tag_index  = fsm_busy ? fill_index : cpu_index; // the fill owns the tag array

cache_ctrl u_ctrl (
	.cpu_req(cpu_req), .entry(entry), .fsm_busy(fsm_busy),
	.mem_read(mem_read), .mem_read_addr(mem_read_addr),
	.hit(hit), .stall(stall), .miss_detected(miss_detected),
	.store_wr(store_wr), .mem_req(mem_req)
);

cache_fill_fsm u_fill_fsm (
	.clk(clk), .arst_n(arst_n), .miss_detected(miss_detected),
	.miss_addr(cpu_req.addr), .mem_rsp(mem_rsp), .fsm_busy(fsm_busy),
	.mem_read(mem_read), .mem_read_addr(mem_read_addr),
	.write_data_array(write_data_array), .fill_offset(fill_offset),
	.fill_data(fill_data), .write_tag_array(write_tag_array), .base_addr(base_addr)
);

// a finished fill marks the set valid with the tag of the fetched block
tag_array u_tag_array (
	.clk(clk), .arst_n(arst_n), .index(tag_index), .wr(write_tag_array),
	.wentry('{valid: 1'b1, tag: base_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]}),
	.rentry(entry)
);

data_array u_data_array (
	.clk(clk), .index(cpu_index), .rd_offset(cpu_req.addr[`CACHE_OFFSET_W-1:0]),
	.fill_wr(write_data_array), .fill_index(fill_index), .fill_offset(fill_offset),
	.fill_data(fill_data), .store_wr(store_wr), .store_data(cpu_req.wdata),
	.rdata(rdata)
);

main_memory u_main_memory (
	.clk(clk), .arst_n(arst_n), .req(mem_req), .rsp(mem_rsp)
);

endmodule

// File: src/data_array.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module data_array (
	input  logic               clk,
	input  cache_pkg::index_t  index,       // set addressed by the processor
	input  cache_pkg::offset_t rd_offset,   // byte offset addressed by the processor
	input  logic               fill_wr,     // word returned by memory during a fill
	input  cache_pkg::index_t  fill_index,
	input  cache_pkg::offset_t fill_offset,
	input  cache_pkg::word_t   fill_data,
	input  logic               store_wr,    // write hit from the processor
	input  cache_pkg::word_t   store_data,
	output cache_pkg::word_t   rdata
);

import cache_pkg::*;

localparam int SETS = 1 << `CACHE_INDEX_W;
localparam int WORD_SEL_W = `CACHE_OFFSET_W - 1; // offset bit 0 picks a byte and is ignored

word_t blocks [SETS][`CACHE_WORDS_PER_BLOCK];

logic [WORD_SEL_W-1:0] rd_word;   // word inside the block for reads and stores
logic [WORD_SEL_W-1:0] fill_word; // word inside the block being filled

assign rd_word   = rd_offset[`CACHE_OFFSET_W-1:1];
assign fill_word = fill_offset[`CACHE_OFFSET_W-1:1];

// ***************************************************************************
// write ports
// ***************************************************************************
always_ff @(posedge clk) begin
	if (fill_wr)
		blocks[fill_index][fill_word] <= fill_data;
	if (store_wr)
		blocks[index][rd_word] <= store_data; // store shares the read address
end

assign rdata = blocks[index][rd_word]; // combinational so a hit answers in one cycle

// a store only happens while the FSM is idle and a fill only while it is busy
a_one_write_port: assert property (@(posedge clk) !(fill_wr && store_wr));

endmodule

// File: src/main_memory.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module main_memory #(
	parameter int LATENCY = `MEM_LATENCY // any value of 1 or more works
) (
	input  logic                clk,
	input  logic                arst_n,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::mem_rsp_t rsp
);

import cache_pkg::*;

localparam int WORD_ADDR_W = $clog2(`MEM_WORDS);

word_t mem [`MEM_WORDS];

logic [WORD_ADDR_W-1:0] word_addr; // byte address with the byte select bit dropped
logic [LATENCY-1:0]     valid_q;   // one bit per read in flight
word_t                  data_q [LATENCY];

assign word_addr = req.addr[WORD_ADDR_W:1];

// ***************************************************************************
// write port
// ***************************************************************************
always_ff @(posedge clk) begin
	if (req.wr)
		mem[word_addr] <= req.wdata; // writes finish in one cycle and never back up
end

// ***************************************************************************
// read pipeline
// ***************************************************************************
// valid bits are control and come out of reset empty
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		valid_q <= '0;
	end else begin
		valid_q[0] <= req.rd;
		for (int i = 1; i < LATENCY; i++)
			valid_q[i] <= valid_q[i-1];
	end
end

// the data moves along beside its valid bit
always_ff @(posedge clk) begin
	data_q[0] <= mem[word_addr];
	for (int i = 1; i < LATENCY; i++)
		data_q[i] <= data_q[i-1];
end

assign rsp = '{valid: valid_q[LATENCY-1], data: data_q[LATENCY-1]}; // oldest read comes out first

// the cache never mixes a fill read with a write-through store
a_no_rd_and_wr: assert property (@(posedge clk) disable iff (!arst_n)
	!(req.rd && req.wr));

endmodule

// File: src/tag_array.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tag_array (
	input  logic                  clk,
	input  logic                  arst_n,
	input  cache_pkg::index_t     index,  // set being looked up or written
	input  logic                  wr,     // pulses once at the end of a fill
	input  cache_pkg::tag_entry_t wentry,
	output cache_pkg::tag_entry_t rentry  // read back in the same cycle
);

import cache_pkg::*;

localparam int SETS = 1 << `CACHE_INDEX_W;

logic [SETS-1:0] valid_q;   // one valid bit per set
tag_t            tag_q [SETS];

// ***************************************************************************
// valid bits
// ***************************************************************************
// after reset every set is empty, so the first access to any address misses
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		valid_q <= '0;
	end else if (wr) begin
		valid_q[index] <= wentry.valid;
	end
end

// ***************************************************************************
// tag storage
// ***************************************************************************
always_ff @(posedge clk) begin
	if (wr)
		tag_q[index] <= wentry.tag; // replaces whatever block held this set before
end

// combinational read keeps a hit visible in the cycle of the request
assign rentry = '{valid: valid_q[index], tag: tag_q[index]};

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

import cache_pkg::*;

localparam int CLK_PERIOD   = 100;
localparam int NUM_TESTS    = 5;
localparam int MISS_STALLS  = 10 + `MEM_LATENCY; // miss cycle, fill and the tag write cycle
localparam int ACCESS_LIMIT = 4 * MISS_STALLS;   // a held access gives up after this many stalls
localparam int SETS         = 1 << `CACHE_INDEX_W;

logic     clk;
logic     arst_n;
cpu_req_t cpu_req;
word_t    rdata;
logic     stall;
logic     hit;

word_t  ref_mem [addr_t];  // every word written so far, keyed by its byte address
logic   tag_valid [SETS];  // which block each set should hold by now
tag_t   tag_held [SETS];
integer seed = 32'h5d3a;
int     err_cnt;
int     tests_ok;
int     tests_bad;

// results of the last processor access
word_t last_data;
logic  last_hit;
logic  last_first_stall; // stall seen in the first cycle of the access
logic  last_first_hit;
int    last_stalls;      // cycles spent with stall high
logic  last_done;

cache_top uut (
	.clk(clk), .arst_n(arst_n), .cpu_req(cpu_req),
	.rdata(rdata), .stall(stall), .hit(hit)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD/2) clk = ~clk;
end

// ***************************************************************************
// reference model of the cache contents
// ***************************************************************************
function automatic index_t index_of(addr_t a);
	return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
endfunction

function automatic tag_t tag_of(addr_t a);
	return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
endfunction

function automatic logic in_cache(addr_t a);
	return tag_valid[index_of(a)] && (tag_held[index_of(a)] == tag_of(a));
endfunction

// a completed read leaves its block in the set, whatever was there before
task automatic note_fill(input addr_t a);
	tag_valid[index_of(a)] = 1'b1;
	tag_held[index_of(a)]  = tag_of(a);
endtask

task automatic flag_mismatch(input string msg);
	$display("FAIL %0t: %s", $time, msg);
	err_cnt++;
endtask

// ***************************************************************************
// processor side access
// ***************************************************************************
// drives on the falling edge and samples a quarter period later, well clear of both edges
task automatic cpu_access(input logic is_read, input addr_t addr, input word_t wdata);
	@(negedge clk);
	cpu_req.rd    = is_read;
	cpu_req.wr    = !is_read;
	cpu_req.addr  = addr;
	cpu_req.wdata = wdata;
	#(CLK_PERIOD/4);
	last_first_stall = stall;
	last_first_hit   = hit;
	last_stalls      = 0;
	while (stall && last_stalls < ACCESS_LIMIT) begin
		last_stalls++; // request stays put while the cache is busy
		@(negedge clk);
		#(CLK_PERIOD/4);
	end
	last_done = !stall;
	last_data = rdata;
	last_hit  = hit;
	@(negedge clk);
	cpu_req = '0; // bus goes idle after the completing edge
endtask

task automatic check_read(input addr_t a);
	logic exp_hit;
	exp_hit = in_cache(a);
	cpu_access(1'b1, a, '0);
	assert (last_done) else begin
		$display("read of 0x%h never completed, stall stayed high at %0t", a, $time);
		err_cnt++;
	end
	if (last_done) begin
		assert (last_first_stall == !exp_hit) else
			flag_mismatch($sformatf("read 0x%h first-cycle stall %b, expected %b",
				a, last_first_stall, !exp_hit));
		if (!exp_hit) begin
			assert (last_stalls == MISS_STALLS) else
				flag_mismatch($sformatf("read 0x%h stalled %0d cycles, expected %0d",
					a, last_stalls, MISS_STALLS));
		end
		assert (last_hit) else flag_mismatch($sformatf("read 0x%h completed without hit", a));
		assert (last_data == ref_mem[a]) else
			flag_mismatch($sformatf("read 0x%h returned 0x%h, expected 0x%h",
				a, last_data, ref_mem[a]));
		note_fill(a);
	end
endtask

// stores are write-through and never allocate, so the model only changes memory
task automatic check_write(input addr_t a, input word_t d);
	logic exp_hit;
	exp_hit = in_cache(a);
	cpu_access(1'b0, a, d);
	assert (last_stalls == 0) else
		flag_mismatch($sformatf("write 0x%h stalled %0d cycles", a, last_stalls));
	assert (last_first_hit == exp_hit) else
		flag_mismatch($sformatf("write 0x%h hit %b, expected %b", a, last_first_hit, exp_hit));
	ref_mem[a] = d;
endtask

task automatic report_test(input string name, input int errs_before);
	if (err_cnt == errs_before) begin
		tests_ok++;
		$display("%-22s ok", name);
	end else begin
		tests_bad++;
		$display("%-22s %0d errors", name, err_cnt - errs_before);
	end
endtask

// ***************************************************************************
// directed tests
// ***************************************************************************
task automatic test_reset_state();
	int errs;
	errs = err_cnt;
	cpu_access(1'b1, 16'h0010, '0); // every set is empty, data here is whatever memory held
	assert (last_first_stall && !last_first_hit) else
		flag_mismatch($sformatf("read after reset stall %b hit %b, expected 1 0",
			last_first_stall, last_first_hit));
	assert (last_done) else begin
		$display("first read after reset never completed at %0t", $time);
		err_cnt++;
	end
	note_fill(16'h0010);
	check_write(16'h0020, word_t'($random(seed)));
	report_test("reset state", errs);
endtask

task automatic test_block_fill();
	int errs;
	int i;
	errs = err_cnt;
	for (i = 0; i < `CACHE_WORDS_PER_BLOCK; i++)
		check_write(16'h1040 + addr_t'(2 * i), word_t'($random(seed)));
	check_read(16'h1046); // misses and waits out the whole fill
	report_test("block fill", errs);
endtask

task automatic test_block_hits();
	int errs;
	int i;
	errs = err_cnt;
	for (i = 0; i < `CACHE_WORDS_PER_BLOCK; i++) begin
		if (i != 3)
			check_read(16'h1040 + addr_t'(2 * i));
	end
	report_test("block hits", errs);
endtask

task automatic test_write_through();
	int errs;
	errs = err_cnt;
	check_write(16'h1048, word_t'($random(seed))); // hit, so the cached copy changes too
	check_read(16'h1048);
	check_write(16'h2048, word_t'($random(seed))); // same set with another tag, memory only
	check_read(16'h2048);  // evicts the first block
	check_read(16'h1048);  // refetched, so the new word must have reached memory
	assert (last_first_stall) else flag_mismatch("read after eviction did not miss");
	report_test("write through", errs);
endtask

task automatic test_random();
	int     errs;
	int     i;
	int     j;
	addr_t  bases [4];
	addr_t  order [$];
	bit     seen [addr_t];
	addr_t  a;
	word_t  d;
	errs = err_cnt;
	for (i = 0; i < 3; i++)
		bases[i] = addr_t'($random(seed)) & 16'hfff0;
	bases[3] = bases[0] ^ 16'h8000; // same index as the first block so one replaces the other
	for (i = 0; i < 40; i++) begin
		a = bases[$unsigned($random(seed)) % 4] + addr_t'(($unsigned($random(seed)) % 8) * 2);
		d = word_t'($random(seed));
		if (!seen.exists(a)) begin
			seen[a] = 1'b1;
			order.push_back(a);
		end
		check_write(a, d);
	end
	// shuffle the read order with the same seeded generator
	for (i = order.size() - 1; i > 0; i--) begin
		j        = $unsigned($random(seed)) % (i + 1);
		a        = order[i];
		order[i] = order[j];
		order[j] = a;
	end
	foreach (order[k])
		check_read(order[k]);
	report_test("random sequence", errs);
endtask

// ***************************************************************************
// main sequence and watchdog
// ***************************************************************************
initial begin
	arst_n    = 1'b0;
	cpu_req   = '0;
	err_cnt   = 0;
	tests_ok  = 0;
	tests_bad = 0;
	foreach (tag_valid[s])
		tag_valid[s] = 1'b0;
	repeat (5) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
	test_reset_state();
	test_block_fill();
	test_block_hits();
	test_write_through();
	test_random();
	$display("summary: %0d tests, %0d ok, %0d with errors", NUM_TESTS, tests_ok, tests_bad);
	if (tests_bad == 0 && err_cnt == 0) begin
		$display("test passed");
	end else begin
		$display("test failed");
	end
	$finish;
end

// each test gets a generous budget of cycles on top of reset
initial begin
	repeat (NUM_TESTS * 400 + 100) @(posedge clk);
	$display("watchdog expired before the tests finished");
	$display("test failed");
	$finish;
end

endmodule
